// File: verilog.f
+incdir+.
sldu_pkg.sv
sldu_insn_queue.sv
sldu_slide_engine.sv
sldu_result_queue.sv
sldu_top.sv
tb_sldu.sv

// File: run_sim.sh
#!/bin/sh
# Build the slide unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_sldu \
    -Mdir obj_dir -o sim_sldu; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_sldu
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi
exit 0

// File: tb_sldu.sv
////////////////////////////////////////////////////////////
// Slide unit testbench
// Random slideup and slidedown requests, lane source and
// grant models, shadow register file and reference check
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sldu_defines.svh"

module tb_sldu;

  import sldu_pkg::*;

  localparam int NrLanes   = `SLDU_NR_LANES;
  localparam int LaneBytes = `SLDU_LANE_BYTES;
  localparam int RowBytes  = `SLDU_ROW_BYTES;
  localparam int RegBytes  = `SLDU_ROW_BYTES * `SLDU_ROWS_PER_REG;
  localparam int NumInsn   = 16;
  // Worst case per instruction plus reset and drain
  localparam int TimeoutCycles = NumInsn * 200 + 200;

  logic                     clk_i, rst_ni;
  slide_req_t               req_i;
  logic                     req_valid_i, req_ready_o;
  lane_word_t [NrLanes-1:0] operand_i;
  logic [NrLanes-1:0]       operand_valid_i, operand_ready_o;
  logic [NrLanes-1:0]       result_req_o, result_gnt_i;
  row_addr_t [NrLanes-1:0]  result_addr_o;
  vid_t [NrLanes-1:0]       result_id_o;
  lane_word_t [NrLanes-1:0] result_wdata_o;
  lane_strb_t [NrLanes-1:0] result_be_o;
  logic                     done_o;
  vid_t                     done_id_o;

  // Instruction parameters and source data indexed by register vd
  slide_op_e  op_a     [NumInsn];
  vsew_e      vsew_a   [NumInsn];
  vlen_t      vl_a     [NumInsn];
  vlen_t      stride_a [NumInsn];
  int         src_first [NumInsn];
  int         src_rows  [NumInsn];
  logic [7:0] src_mem  [NumInsn][2*RegBytes];
  // Shadow register file with a write count per byte
  logic [7:0] vrf_data [NumInsn*RegBytes];
  int         wr_cnt   [NumInsn*RegBytes];
  logic [7:0] exp_data [RegBytes];
  logic       exp_strb [RegBytes];
  logic       vd_done  [NumInsn];

  logic [31:0] lcg_state = 32'd66026;
  int          cycle_cnt, n_accepted, n_done, ready_low_cnt;
  int          lane_insn, lane_row, lane_left;
  logic        lane_loaded, stall_en;

  sldu_top i_sldu_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic int next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]);
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    stop_run($sformatf("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // Reference byte mapping
  ////////////////////////////////////////////////////////////

  function automatic void ref_slide(input int n);
    int off;
    int tot;
    off = int'(stride_a[n]) << vsew_a[n];
    tot = int'(vl_a[n]) << vsew_a[n];
    for (int k = 0; k < RegBytes; k++) begin
      exp_strb[k] = 1'b0;
      exp_data[k] = 8'h00;
      if (op_a[n] == SLIDE_UP && k >= off && k < tot) begin
        exp_strb[k] = 1'b1;
        exp_data[k] = src_mem[n][k-off];
      end else if (op_a[n] == SLIDE_DOWN && k < tot) begin
        exp_strb[k] = 1'b1;
        exp_data[k] = src_mem[n][k+off];
      end
    end
  endfunction

  task automatic check_register(input int n);
    int idx;
    ref_slide(n);
    for (int k = 0; k < RegBytes; k++) begin
      idx = n * RegBytes + k;
      assert (wr_cnt[idx] == int'(exp_strb[k])) else
        stop_run($sformatf("Byte %0d of v%0d written %0d times, expected %0d",
                           k, n, wr_cnt[idx], exp_strb[k]));
      if (exp_strb[k]) begin
        assert (vrf_data[idx] == exp_data[k]) else
          value_error($sformatf("result_wdata_o v%0d byte %0d", n, k), vrf_data[idx], exp_data[k]);
      end
    end
  endtask

  // Random parameters with the first two fixed to one slide each way
  task automatic setup_tests();
    int off;
    int tot;
    int cnt;
    int max_el;
    for (int n = 0; n < NumInsn; n++) begin
      op_a[n]   = (n % 2 == 0) ? SLIDE_UP : SLIDE_DOWN;
      vsew_a[n] = vsew_e'(next_random() % 4);
      max_el    = RegBytes >> vsew_a[n];
      vl_a[n]     = vlen_t'(next_random() % (max_el + 1));
      stride_a[n] = vlen_t'(next_random() % max_el);
      for (int b = 0; b < 2 * RegBytes; b++) begin
        src_mem[n][b] = 8'(next_random());
      end
      vd_done[n] = 1'b0;
    end
    vsew_a[0] = EW16;
    vl_a[0] = 8'd50;
    stride_a[0] = 8'd13;
    // Offset 40 makes the source cross a row boundary
    vsew_a[1] = EW8;
    vl_a[1] = 8'd70;
    stride_a[1] = 8'd40;
    // Source rows the lanes must serve in order
    for (int n = 0; n < NumInsn; n++) begin
      off = int'(stride_a[n]) << vsew_a[n];
      tot = int'(vl_a[n]) << vsew_a[n];
      cnt = (tot > off) ? tot - off : 0;
      src_first[n] = (op_a[n] == SLIDE_UP) ? 0 : off / RowBytes;
      if (op_a[n] == SLIDE_UP) begin
        src_rows[n] = (cnt + RowBytes - 1) / RowBytes;
      end else begin
        src_rows[n] = (tot == 0) ? 0 : (off + tot - 1) / RowBytes - src_first[n] + 1;
      end
    end
    for (int i = 0; i < NumInsn * RegBytes; i++) begin
      vrf_data[i] = 8'h00;
      wr_cnt[i]   = 0;
    end
  endtask

  task automatic send_request(input int n);
    logic taken;
    @(negedge clk_i);
    req_i        = '0;
    req_i.op     = op_a[n];
    req_i.id     = vid_t'(n % 8);
    req_i.vd     = vreg_t'(n);
    req_i.vl     = vl_a[n];
    req_i.vsew   = vsew_a[n];
    req_i.stride = stride_a[n];
    req_valid_i  = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk_i);
      taken = req_ready_o;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor sampled on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    int vd;
    int idx;
    cycle_cnt++;
    assert (cycle_cnt < TimeoutCycles) else
      stop_run($sformatf("Timeout after %0d cycles with %0d of %0d instructions done",
                         cycle_cnt, n_done, NumInsn));
    // Granted writes go to the shadow file
    for (int l = 0; l < NrLanes; l++) begin
      if (result_req_o[l] && result_gnt_i[l]) begin
        vd = int'(result_addr_o[l]) / `SLDU_ROWS_PER_REG;
        assert (vd < n_accepted && !vd_done[vd]) else
          stop_run($sformatf("Write to v%0d with no unfinished instruction", vd));
        assert (result_id_o[l] == vid_t'(vd % 8)) else
          value_error("result_id_o", result_id_o[l], vd % 8);
        for (int j = 0; j < LaneBytes; j++) begin
          if (result_be_o[l][j]) begin
            idx = int'(result_addr_o[l]) * RowBytes + l * LaneBytes + j;
            wr_cnt[idx]++;
            vrf_data[idx] = result_wdata_o[l][8*j +: 8];
          end
        end
      end
    end
    // Done must name the oldest unfinished instruction
    if (done_o) begin
      assert (n_done < n_accepted) else
        stop_run("Done pulse with no unfinished instruction");
      assert (done_id_o == vid_t'(n_done % 8)) else
        value_error("done_id_o", done_id_o, n_done % 8);
      check_register(n_done);
      vd_done[n_done] = 1'b1;
      n_done++;
    end
    // Lane model steps to the next source row
    if (operand_ready_o != '0) begin
      assert (operand_ready_o == '1 && lane_loaded) else
        stop_run("Operand ready pulsed on some lanes only or with no row presented");
      lane_row++;
      lane_left--;
      if (lane_left == 0) begin
        lane_loaded = 1'b0;
        lane_insn++;
      end
    end
    if (req_valid_i && req_ready_o) begin
      n_accepted++;
    end
    if (req_valid_i && !req_ready_o) begin
      ready_low_cnt++;
    end
    // Instructions without source rows are skipped
    while (!lane_loaded && lane_insn < n_accepted) begin
      if (src_rows[lane_insn] != 0) begin
        lane_loaded = 1'b1;
        lane_row    = src_first[lane_insn];
        lane_left   = src_rows[lane_insn];
      end else begin
        lane_insn++;
      end
    end
  end

  // Lane source rows and grants change on the falling edge
  always @(negedge clk_i) begin
    operand_valid_i = {NrLanes{lane_loaded}};
    for (int l = 0; l < NrLanes; l++) begin
      for (int j = 0; j < LaneBytes; j++) begin
        operand_i[l][8*j +: 8] = lane_loaded ?
          src_mem[lane_insn][lane_row * RowBytes + l * LaneBytes + j] : 8'h00;
      end
      result_gnt_i[l] = stall_en ? (next_random() % 4 != 0) : 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_ni          = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    result_gnt_i    = '0;
    cycle_cnt       = 0;
    n_accepted      = 0;
    n_done          = 0;
    ready_low_cnt   = 0;
    lane_insn       = 0;
    lane_row        = 0;
    lane_left       = 0;
    lane_loaded     = 1'b0;
    stall_en        = 1'b0;
    setup_tests();
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (req_ready_o === 1'b1) else value_error("req_ready_o", req_ready_o, 1);
    assert (operand_ready_o === '0) else value_error("operand_ready_o", operand_ready_o, 0);
    assert (result_req_o === '0) else value_error("result_req_o", result_req_o, 0);
    assert (done_o === 1'b0) else value_error("done_o", done_o, 0);
    // First half back to back with free grants
    for (int n = 0; n < NumInsn / 2; n++) begin
      send_request(n);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    wait (n_done == NumInsn / 2);
    // Second half with random grant stalls
    stall_en = 1'b1;
    for (int n = NumInsn / 2; n < NumInsn; n++) begin
      send_request(n);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    wait (n_done == NumInsn);
    repeat (20) @(negedge clk_i);
    assert (ready_low_cnt > 0) else
      stop_run("req_ready_o never dropped under back-to-back requests");
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: sldu_top.sv
////////////////////////////////////////////////////////////
// Slide unit top level
// Instruction queue, slide engine and result queue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sldu_defines.svh"

module sldu_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Requests
  input  sldu_pkg::slide_req_t                      req_i,
  input  logic                                      req_valid_i,
  output logic                                      req_ready_o,
  // Source rows from the lanes
  input  sldu_pkg::lane_word_t [`SLDU_NR_LANES-1:0] operand_i,
  input  logic [`SLDU_NR_LANES-1:0]                 operand_valid_i,
  output logic [`SLDU_NR_LANES-1:0]                 operand_ready_o,
  // Result writes to the lanes
  output logic [`SLDU_NR_LANES-1:0]                 result_req_o,
  output sldu_pkg::row_addr_t [`SLDU_NR_LANES-1:0]  result_addr_o,
  output sldu_pkg::vid_t [`SLDU_NR_LANES-1:0]       result_id_o,
  output sldu_pkg::lane_word_t [`SLDU_NR_LANES-1:0] result_wdata_o,
  output sldu_pkg::lane_strb_t [`SLDU_NR_LANES-1:0] result_be_o,
  input  logic [`SLDU_NR_LANES-1:0]                 result_gnt_i,
  // Completion
  output logic                                      done_o,
  output sldu_pkg::vid_t                            done_id_o
);

  import sldu_pkg::*;

  localparam int unsigned NrLanes = `SLDU_NR_LANES;

  // Queue to engine
  slide_req_t               issue_req;
  logic                     issue_valid;
  logic                     issue_done;
  // Engine to result queue
  logic                     push;
  row_addr_t                push_addr;
  vid_t                     push_id;
  lane_word_t [NrLanes-1:0] push_wdata;
  lane_strb_t [NrLanes-1:0] push_be;
  logic                     result_full;
  // Result queue back to the instruction queue
  logic                     row_retired;

  sldu_insn_queue i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .issue_req_o   (issue_req),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .row_retired_i (row_retired),
    .done_o        (done_o),
    .done_id_o     (done_id_o)
  );

  sldu_slide_engine i_slide_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_req_i     (issue_req),
    .issue_valid_i   (issue_valid),
    .issue_done_o    (issue_done),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_full_i   (result_full),
    .push_o          (push),
    .push_addr_o     (push_addr),
    .push_id_o       (push_id),
    .push_wdata_o    (push_wdata),
    .push_be_o       (push_be)
  );

  sldu_result_queue i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_addr_i    (push_addr),
    .push_id_i      (push_id),
    .push_wdata_i   (push_wdata),
    .push_be_i      (push_be),
    .result_full_o  (result_full),
    .result_req_o   (result_req_o),
    .result_addr_o  (result_addr_o),
    .result_id_o    (result_id_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .row_retired_o  (row_retired)
  );

endmodule

// File: sldu_result_queue.sv
////////////////////////////////////////////////////////////
// Slide result queue
// Two-entry row buffer writing each row to the lanes by
// request and grant, retiring it once all lanes granted
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sldu_defines.svh"

module sldu_result_queue (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      push_i,
  input  sldu_pkg::row_addr_t                       push_addr_i,
  input  sldu_pkg::vid_t                            push_id_i,
  input  sldu_pkg::lane_word_t [`SLDU_NR_LANES-1:0] push_wdata_i,
  input  sldu_pkg::lane_strb_t [`SLDU_NR_LANES-1:0] push_be_i,
  output logic                                      result_full_o,
  output logic [`SLDU_NR_LANES-1:0]                 result_req_o,
  output sldu_pkg::row_addr_t [`SLDU_NR_LANES-1:0]  result_addr_o,
  output sldu_pkg::vid_t [`SLDU_NR_LANES-1:0]       result_id_o,
  output sldu_pkg::lane_word_t [`SLDU_NR_LANES-1:0] result_wdata_o,
  output sldu_pkg::lane_strb_t [`SLDU_NR_LANES-1:0] result_be_o,
  input  logic [`SLDU_NR_LANES-1:0]                 result_gnt_i,
  output logic                                      row_retired_o
);

  import sldu_pkg::*;

  localparam int unsigned Depth   = `SLDU_RESULT_DEPTH;
  localparam int unsigned NrLanes = `SLDU_NR_LANES;
  localparam int unsigned PntW    = $clog2(Depth);

  row_addr_t                     addr_q  [Depth];
  vid_t                          id_q    [Depth];
  lane_word_t [NrLanes-1:0]      wdata_q [Depth];
  lane_strb_t [NrLanes-1:0]      be_q    [Depth];
  // Lanes still waiting for a grant, per entry
  logic [Depth-1:0][NrLanes-1:0] valid_q, valid_d;
  logic [PntW-1:0]               wr_pnt_q, rd_pnt_q;
  logic [PntW:0]                 cnt_q;
  logic                          retire;

  assign result_full_o = (cnt_q == (PntW+1)'(Depth));

  // Head entry goes out on every lane
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      result_req_o[l]   = valid_q[rd_pnt_q][l];
      result_addr_o[l]  = addr_q[rd_pnt_q];
      result_id_o[l]    = id_q[rd_pnt_q];
      result_wdata_o[l] = wdata_q[rd_pnt_q][l];
      result_be_o[l]    = be_q[rd_pnt_q][l];
    end
  end

  always_comb begin
    valid_d = valid_q;
    // A grant drops that lane's request
    valid_d[rd_pnt_q] = valid_q[rd_pnt_q] & ~result_gnt_i;
    // Head retires when no lane is left waiting
    retire = (cnt_q != '0) && (valid_d[rd_pnt_q] == '0);
    if (push_i) begin
      valid_d[wr_pnt_q] = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q       <= '0;
      wr_pnt_q      <= '0;
      rd_pnt_q      <= '0;
      cnt_q         <= '0;
      row_retired_o <= 1'b0;
    end else begin
      valid_q       <= valid_d;
      wr_pnt_q      <= wr_pnt_q + PntW'(push_i);
      rd_pnt_q      <= rd_pnt_q + PntW'(retire);
      cnt_q         <= cnt_q + (PntW+1)'(push_i) - (PntW+1)'(retire);
      row_retired_o <= retire;
    end
  end

  // Row payload
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_q[wr_pnt_q]  <= push_addr_i;
      id_q[wr_pnt_q]    <= push_id_i;
      wdata_q[wr_pnt_q] <= push_wdata_i;
      be_q[wr_pnt_q]    <= push_be_i;
    end
  end

endmodule

// File: sldu_slide_engine.sv
////////////////////////////////////////////////////////////
// Slide engine
// Copies source row bytes into destination rows at the
// slide offset and pushes each finished row
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sldu_defines.svh"

module sldu_slide_engine (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  sldu_pkg::slide_req_t                      issue_req_i,
  input  logic                                      issue_valid_i,
  output logic                                      issue_done_o,
  input  sldu_pkg::lane_word_t [`SLDU_NR_LANES-1:0] operand_i,
  input  logic [`SLDU_NR_LANES-1:0]                 operand_valid_i,
  output logic [`SLDU_NR_LANES-1:0]                 operand_ready_o,
  input  logic                                      result_full_i,
  output logic                                      push_o,
  output sldu_pkg::row_addr_t                       push_addr_o,
  output sldu_pkg::vid_t                            push_id_o,
  output sldu_pkg::lane_word_t [`SLDU_NR_LANES-1:0] push_wdata_o,
  output sldu_pkg::lane_strb_t [`SLDU_NR_LANES-1:0] push_be_o
);

  import sldu_pkg::*;

  localparam int unsigned NrLanes  = `SLDU_NR_LANES;
  localparam int unsigned LaneB    = `SLDU_LANE_BYTES;
  localparam int unsigned RowB     = `SLDU_ROW_BYTES;
  localparam int unsigned RowShift = $clog2(RowB);
  localparam int unsigned VrfW     = $clog2(`SLDU_ROWS_PER_REG);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    RUN
  } state_e;

  state_e                   state_q, state_d;
  // Byte pointers within the source and destination rows
  logic [RowShift:0]        in_pnt_q, in_pnt_d, out_pnt_q, out_pnt_d;
  // Bytes still to be moved
  vlen_t                    cnt_q, cnt_d;
  // Destination row within the register
  logic [VrfW-1:0]          vrf_pnt_q, vrf_pnt_d;
  // Destination row under construction
  lane_word_t [NrLanes-1:0] row_data_q, row_data_d;
  lane_strb_t [NrLanes-1:0] row_be_q, row_be_d;
  logic [10:0]              total, offset;

  // Byte total and byte offset of the issuing instruction
  assign total  = 11'(issue_req_i.vl) << issue_req_i.vsew;
  assign offset = 11'(issue_req_i.stride) << issue_req_i.vsew;

  assign push_addr_o  = {issue_req_i.vd, vrf_pnt_q};
  assign push_id_o    = issue_req_i.id;
  assign push_wdata_o = row_data_d;
  assign push_be_o    = row_be_d;

  always_comb begin
    int in_left;
    int out_left;
    int n;
    int src;
    int dst;

    state_d         = state_q;
    in_pnt_d        = in_pnt_q;
    out_pnt_d       = out_pnt_q;
    cnt_d           = cnt_q;
    vrf_pnt_d       = vrf_pnt_q;
    row_data_d      = row_data_q;
    row_be_d        = row_be_q;
    issue_done_o    = 1'b0;
    operand_ready_o = '0;
    push_o          = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (issue_valid_i) begin
          state_d = SETUP;
        end
      end

      SETUP: begin
        if (issue_req_i.op == SLIDE_UP) begin
          // Read from the start, write from the offset on
          in_pnt_d  = '0;
          out_pnt_d = {1'b0, offset[RowShift-1:0]};
          cnt_d     = (total > offset) ? vlen_t'(total - offset) : '0;
          vrf_pnt_d = offset[RowShift +: VrfW];
        end else begin
          // Read from the offset on, write from the start
          in_pnt_d  = {1'b0, offset[RowShift-1:0]};
          out_pnt_d = '0;
          cnt_d     = vlen_t'(total);
          vrf_pnt_d = '0;
        end
        // Nothing to write, release the instruction right away
        if (cnt_d == '0) begin
          state_d      = IDLE;
          issue_done_o = 1'b1;
        end else begin
          state_d = RUN;
        end
      end

      RUN: begin
        // Whole source row present and room for a result
        if (&operand_valid_i && !result_full_i) begin
          in_left  = int'(RowB) - int'(in_pnt_q);
          out_left = int'(RowB) - int'(out_pnt_q);
          n        = (in_left < out_left) ? in_left : out_left;
          if (int'(cnt_q) < n) begin
            n = int'(cnt_q);
          end

          for (int b = 0; b < RowB; b++) begin
            if (b < n) begin
              src = int'(in_pnt_q) + b;
              dst = int'(out_pnt_q) + b;
              // Byte b of a row sits in lane b/8 at offset b%8
              row_data_d[dst/LaneB][8*(dst%LaneB) +: 8] = operand_i[src/LaneB][8*(src%LaneB) +: 8];
              row_be_d[dst/LaneB][dst%LaneB] = 1'b1;
            end
          end

          in_pnt_d  = in_pnt_q + (RowShift+1)'(n);
          out_pnt_d = out_pnt_q + (RowShift+1)'(n);
          cnt_d     = cnt_q - vlen_t'(n);

          // Source row used up or last bytes moved
          if (in_pnt_d == (RowShift+1)'(RowB) || cnt_d == '0) begin
            in_pnt_d        = '0;
            operand_ready_o = '1;
          end

          // Destination row full or last bytes moved
          if (out_pnt_d == (RowShift+1)'(RowB) || cnt_d == '0) begin
            out_pnt_d = '0;
            push_o    = 1'b1;
            vrf_pnt_d = vrf_pnt_q + VrfW'(1);
          end

          if (cnt_d == '0) begin
            state_d      = IDLE;
            issue_done_o = 1'b1;
          end
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      cnt_q     <= '0;
      vrf_pnt_q <= '0;
      row_be_q  <= '0;
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
      cnt_q     <= cnt_d;
      vrf_pnt_q <= vrf_pnt_d;
      // A pushed row starts over empty
      row_be_q  <= push_o ? '0 : row_be_d;
    end
  end

  always_ff @(posedge clk_i) begin
    row_data_q <= row_data_d;
  end

endmodule

// File: sldu_insn_queue.sv
////////////////////////////////////////////////////////////
// Slide instruction queue
// Ring of requests with accept, issue and commit phases.
// Counts retired rows of the oldest instruction and
// pulses done with its id
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sldu_defines.svh"

module sldu_insn_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  sldu_pkg::slide_req_t req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output sldu_pkg::slide_req_t issue_req_o,
  output logic                 issue_valid_o,
  input  logic                 issue_done_i,
  input  logic                 row_retired_i,
  output logic                 done_o,
  output sldu_pkg::vid_t       done_id_o
);

  import sldu_pkg::*;

  localparam int unsigned Depth    = `SLDU_INSN_DEPTH;
  localparam int unsigned PntW     = $clog2(Depth);
  localparam int unsigned RowShift = $clog2(`SLDU_ROW_BYTES);

  // Rows the byte mapping touches for one request
  function automatic logic [2:0] row_count(slide_req_t r);
    logic [10:0] total;
    logic [10:0] offset;
    logic [10:0] rows;
    total  = 11'(r.vl) << r.vsew;
    offset = 11'(r.stride) << r.vsew;
    rows   = '0;
    if (r.op == SLIDE_UP) begin
      // Rows from the one holding the offset up to the last byte
      if (total > offset) begin
        rows = ((total - 11'd1) >> RowShift) - (offset >> RowShift) + 11'd1;
      end
    end else if (total != '0) begin
      rows = (total + 11'(`SLDU_ROW_BYTES - 1)) >> RowShift;
    end
    return rows[2:0];
  endfunction

  slide_req_t      mem_q [Depth];
  logic [PntW-1:0] accept_pnt_q, issue_pnt_q, issue_pnt_d, commit_pnt_q;
  logic [PntW:0]   issue_cnt_q, issue_cnt_d, commit_cnt_q, commit_cnt_d;
  logic [2:0]      rows_left_q, rows_left_d, rows_dec;
  logic            accept, commit_valid, issued, finish;
  slide_req_t      commit_req, head_next, issue_next;

  ////////////////////////////////////////////////////////////
  // Accept and issue
  ////////////////////////////////////////////////////////////

  assign req_ready_o = (commit_cnt_q != (PntW+1)'(Depth));
  assign accept      = req_valid_i && req_ready_o;

  assign issue_pnt_d = issue_pnt_q + PntW'(issue_done_i);
  assign issue_cnt_d = issue_cnt_q + (PntW+1)'(accept) - (PntW+1)'(issue_done_i);

  // Next issue entry may be the one written in this cycle
  assign issue_next = (accept && accept_pnt_q == issue_pnt_d) ? req_i : mem_q[issue_pnt_d];

  ////////////////////////////////////////////////////////////
  // Commit
  ////////////////////////////////////////////////////////////

  assign commit_valid = (commit_cnt_q != '0);
  assign commit_req   = mem_q[commit_pnt_q];
  // Commit head is older than the issuing one once the engine let go of it
  assign issued       = (commit_cnt_q > issue_cnt_q);
  assign rows_dec     = rows_left_q - {2'b0, row_retired_i};
  assign finish       = commit_valid && issued && (rows_dec == '0);

  // Instruction that becomes the commit head next
  assign head_next = (commit_cnt_q > (PntW+1)'(1)) ? mem_q[commit_pnt_q + PntW'(1)] : req_i;

  assign rows_left_d  = (finish || !commit_valid) ? row_count(head_next) : rows_dec;
  assign commit_cnt_d = commit_cnt_q + (PntW+1)'(accept) - (PntW+1)'(finish);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q  <= '0;
      issue_pnt_q   <= '0;
      commit_pnt_q  <= '0;
      issue_cnt_q   <= '0;
      commit_cnt_q  <= '0;
      rows_left_q   <= '0;
      issue_valid_o <= 1'b0;
      done_o        <= 1'b0;
      done_id_o     <= '0;
    end else begin
      accept_pnt_q  <= accept_pnt_q + PntW'(accept);
      issue_pnt_q   <= issue_pnt_d;
      commit_pnt_q  <= commit_pnt_q + PntW'(finish);
      issue_cnt_q   <= issue_cnt_d;
      commit_cnt_q  <= commit_cnt_d;
      rows_left_q   <= rows_left_d;
      issue_valid_o <= (issue_cnt_d != '0);
      done_o        <= finish;
      done_id_o     <= commit_req.id;
    end
  end

  // Request storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= req_i;
    end
    issue_req_o <= issue_next;
  end

endmodule

// File: sldu_pkg.sv
////////////////////////////////////////////////////////////
// Slide unit types
// Opcode, request, lane data and addressing types
////////////////////////////////////////////////////////////

`include "sldu_defines.svh"

package sldu_pkg;

  // Slide direction
  typedef enum logic {
    SLIDE_UP,
    SLIDE_DOWN
  } slide_op_e;

  // Element width, an element is 2**code bytes
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vsew_e;

  typedef logic [2:0] vid_t;
  typedef logic [$clog2(`SLDU_NR_VREGS)-1:0] vreg_t;
  // Element or byte count, up to a full register
  typedef logic [7:0] vlen_t;
  // Register number times rows per register plus row index
  typedef logic [$clog2(`SLDU_NR_VREGS*`SLDU_ROWS_PER_REG)-1:0] row_addr_t;

  typedef logic [8*`SLDU_LANE_BYTES-1:0] lane_word_t;
  typedef logic [`SLDU_LANE_BYTES-1:0] lane_strb_t;

  // Stride counts elements, not bytes
  typedef struct packed {
    slide_op_e op;
    vid_t      id;
    vreg_t     vd;
    vlen_t     vl;
    vsew_e     vsew;
    vlen_t     stride;
  } slide_req_t;

endpackage

// File: sldu_defines.svh
////////////////////////////////////////////////////////////
// Slide unit sizing
// Lane count, queue depths, register geometry and
// element widths shared by the RTL and the testbench
////////////////////////////////////////////////////////////

`ifndef SLDU_DEFINES_SVH
`define SLDU_DEFINES_SVH

// Lanes and bytes per lane word
`define SLDU_NR_LANES 4
`define SLDU_LANE_BYTES 8
// One row spans all lanes
`define SLDU_ROW_BYTES 32

// Queue depths
`define SLDU_INSN_DEPTH 2
`define SLDU_RESULT_DEPTH 2

// Register file geometry, 4 rows make one 128-byte register
`define SLDU_ROWS_PER_REG 4
`define SLDU_NR_VREGS 32

`endif
